// ==== src/z80_bus_pkg.sv ====
// Z80 bus cycle engine shared types
// Holds the host command and T-state encodings together with the
// request, response, strobe and cycle structs used between the
// sequencer, the strobe generator and the bus target
package z80_bus_pkg;

  // Kind of machine cycle requested by the host
  typedef enum logic [2:0] {
    cmd_fetch   = 3'd0, // Opcode fetch with M1 and a refresh slot
    cmd_mem_rd  = 3'd1,
    cmd_mem_wr  = 3'd2,
    cmd_io_rd   = 3'd3,
    cmd_io_wr   = 3'd4,
    cmd_int_ack = 3'd5  // Vector read with IORQ and M1 together
  } bus_cmd_e;

  // T-states of one machine cycle, idle between cycles
  typedef enum logic [2:0] {
    ts_idle = 3'd0,
    ts_t1   = 3'd1,
    ts_t2   = 3'd2,
    ts_tw   = 3'd3, // Inserted while the target holds wait_n low
    ts_t3   = 3'd4,
    ts_t4   = 3'd5  // Refresh state, only reached by a fetch
  } tstate_e;

  // One host command, 27 bits
  typedef struct packed {
    bus_cmd_e    cmd;
    logic [15:0] addr;
    logic [7:0]  wdata; // Ignored by reads and by the acknowledge
  } bus_req_t;

  // Completion data returned to the host, 9 bits
  typedef struct packed {
    logic [7:0] rdata;
    logic       int_ack_seen; // Response closes an interrupt acknowledge
  } bus_rsp_t;

  // External strobes, all active high
  typedef struct packed {
    logic mreq;
    logic iorq;
    logic rd;
    logic wr;
    logic m1;
    logic rfsh;
  } bus_strobes_t;

  // Current position in the machine cycle and the cycle kind
  typedef struct packed {
    tstate_e  tstate;
    bus_cmd_e cmd;
  } cycle_info_t;

endpackage

// ==== src/cycle_sequencer.sv ====
// Machine cycle sequencer
// Accepts a single host command when idle and walks it through
// T1, T2, optional wait states, T3 and the T4 refresh slot of a fetch.
// Keeps the 7-bit refresh counter and latches read data for the response
`timescale 1ns/1ps

module cycle_sequencer (
  input  logic                     cpu_bus,
  input  logic                     arst_n,
  input  logic                     cmd_valid,
  input  z80_bus_pkg::bus_req_t    cmd,
  input  logic                     wait_n,
  input  logic [7:0]               rdata,
  output logic                     busy,
  output z80_bus_pkg::cycle_info_t cycle,
  output logic [15:0]              addr,
  output logic [7:0]               dout,
  output logic                     rsp_valid,
  output z80_bus_pkg::bus_rsp_t    rsp
);
  import z80_bus_pkg::*;

  tstate_e     ts_q;        // Current T-state
  bus_cmd_e    cmd_q;       // Kind of the cycle in flight
  logic        launch_q;    // Command taken, T1 starts on the next edge
  logic        busy_q;
  logic        rsp_valid_q;
  logic [6:0]  rfsh_cnt;    // Counts completed fetches
  logic [15:0] addr_q;      // Address on the bus
  logic [7:0]  wdata_q;     // Data-out bus for writes
  logic [7:0]  rdata_q;     // Read data captured for the response
  logic        int_ack_q;   // Response flag for interrupt acknowledge
  logic        accept;
  logic        last_ts;
  logic        data_phase;
  logic        is_read;

  // A strobe seen while busy is simply lost
  assign accept = cmd_valid && !busy_q;

  // T3 closes every cycle except a fetch, which still owes its T4
  assign last_ts = (ts_q == ts_t4) || ((ts_q == ts_t3) && (cmd_q != cmd_fetch));

  assign data_phase = (ts_q == ts_t2) || (ts_q == ts_tw); // Edges that may close the data phase
  assign is_read    = (cmd_q != cmd_mem_wr) && (cmd_q != cmd_io_wr);

  // Control state and T-state walk
  always_ff @(posedge cpu_bus or negedge arst_n)
  begin
    if (!arst_n)
    begin
      ts_q        <= ts_idle;
      cmd_q       <= cmd_fetch;
      launch_q    <= 1'b0;
      busy_q      <= 1'b0;
      rsp_valid_q <= 1'b0;
      rfsh_cnt    <= 7'd0;
    end
    else
    begin
      rsp_valid_q <= 1'b0; // Response strobe lasts one cycle
      launch_q    <= accept;
      if (accept)
      begin
        busy_q <= 1'b1;
        cmd_q  <= cmd.cmd;
      end
      case (ts_q)
        ts_idle:
        begin
          if (launch_q)
            ts_q <= ts_t1; // First T-state one edge after the command
        end
        ts_t1:
          ts_q <= ts_t2;   // T1 never waits
        ts_t2, ts_tw:
          ts_q <= wait_n ? ts_t3 : ts_tw; // Stretch while the target stalls
        ts_t3:
        begin
          if (cmd_q == cmd_fetch)
            ts_q <= ts_t4;
        end
        ts_t4:
          rfsh_cnt <= rfsh_cnt + 7'd1; // This fetch now counts as an earlier one
        default:
          ts_q <= ts_idle;
      endcase
      if (last_ts)
      begin
        ts_q        <= ts_idle;
        busy_q      <= 1'b0;
        rsp_valid_q <= 1'b1;
      end
    end
  end

  // Address, write data and read data capture
  always_ff @(posedge cpu_bus)
  begin
    if (accept)
    begin
      addr_q    <= cmd.addr;
      wdata_q   <= cmd.wdata;
      int_ack_q <= (cmd.cmd == cmd_int_ack);
    end
    else if ((ts_q == ts_t3) && (cmd_q == cmd_fetch))
    begin
      // Refresh address for T4, kept on the bus until the next command
      addr_q <= {9'd0, rfsh_cnt};
    end
    if (data_phase && wait_n && is_read)
      rdata_q <= rdata; // Data is valid once the target releases wait_n
  end

  assign busy      = busy_q;
  assign cycle     = '{tstate: ts_q, cmd: cmd_q};
  assign addr      = addr_q;
  assign dout      = wdata_q;
  assign rsp_valid = rsp_valid_q;
  assign rsp       = '{rdata: rdata_q, int_ack_seen: int_ack_q};

endmodule

// ==== src/bus_strobe_gen.sv ====
// Bus strobe generator
// Decodes mreq, iorq, rd, wr, m1 and rfsh from the T-state and the cycle
// kind, registers them on the falling clock edge so that wait_n has half
// a cycle to settle, and raises a single access request per cycle
`timescale 1ns/1ps

module bus_strobe_gen #(
  parameter bit t2_write = 1'b1 // 1 puts wr in T1, 0 holds it back to T2
) (
  input  logic                      cpu_bus,
  input  logic                      arst_n,
  input  z80_bus_pkg::cycle_info_t  cycle,
  input  logic                      wait_n,
  output z80_bus_pkg::bus_strobes_t strobes,
  output logic                      access_req
);
  import z80_bus_pkg::*;

  tstate_e      ts;
  bus_strobes_t nxt;        // Strobes for the coming half cycle
  bus_strobes_t strb_q;     // Strobes on the bus
  logic         addr_phase; // T1, T2 or a wait state
  logic         wr_phase;   // States in which wr is driven
  logic         select;
  logic         direction;
  logic         ack_q;      // Request already issued for this access

  assign ts         = cycle.tstate;
  assign addr_phase = (ts == ts_t1) || (ts == ts_t2) || (ts == ts_tw);

  // Early write drops wr as soon as the target stops stalling
  assign wr_phase = t2_write ? ((ts == ts_t1) || (((ts == ts_t2) || (ts == ts_tw)) && !wait_n))
                             : ((ts == ts_t2) || (ts == ts_tw));

  always_comb
  begin
    nxt = '0;
    case (cycle.cmd)
      cmd_fetch:
      begin
        nxt.mreq = addr_phase || (ts == ts_t4); // Select again for the refresh
        nxt.rd   = addr_phase;
        nxt.m1   = addr_phase || (ts == ts_t3);
        nxt.rfsh = (ts == ts_t4);
      end
      cmd_mem_rd:
      begin
        nxt.mreq = addr_phase;
        nxt.rd   = addr_phase;
      end
      cmd_io_rd:
      begin
        nxt.iorq = addr_phase; // I/O space replaces memory select
        nxt.rd   = addr_phase;
      end
      cmd_int_ack:
      begin
        // Vector read is marked by iorq with m1, never by rd
        nxt.iorq = addr_phase;
        nxt.m1   = addr_phase;
      end
      cmd_mem_wr:
      begin
        nxt.mreq = wr_phase;
        nxt.wr   = wr_phase;
      end
      cmd_io_wr:
      begin
        nxt.iorq = wr_phase;
        nxt.wr   = wr_phase;
      end
      default:
        nxt = '0;
    endcase
  end

  // Strobes follow the decoded state half a cycle later
  always_ff @(negedge cpu_bus or negedge arst_n)
  begin
    if (!arst_n)
      strb_q <= '0;
    else
      strb_q <= nxt;
  end

  assign select    = strb_q.mreq || strb_q.iorq;
  // m1 with iorq stands for the read direction of an acknowledge
  assign direction = strb_q.rd || strb_q.wr || strb_q.m1;

  // Acknowledge holds the request off until both selects have dropped
  always_ff @(posedge cpu_bus or negedge arst_n)
  begin
    if (!arst_n)
      ack_q <= 1'b0;
    else if (!strb_q.mreq && !strb_q.iorq)
      ack_q <= 1'b0;
    else if (access_req)
      ack_q <= 1'b1;
  end

  assign access_req = select && direction && !ack_q; // Seen by exactly one rising edge
  assign strobes    = strb_q;

endmodule

// ==== src/bus_target.sv ====
// Bus target model
// Memory plus sixteen I/O registers behind the strobe bus.
// I/O register 14 sets the number of wait states per access and
// register 15 is the vector returned on interrupt acknowledge.
// Each access request reloads the wait counter that drives wait_n
`timescale 1ns/1ps

module bus_target #(
  parameter int mem_words = 256 // Memory depth, a power of two
) (
  input  logic                      cpu_bus,
  input  logic                      arst_n,
  input  z80_bus_pkg::bus_strobes_t strobes,
  input  logic                      access_req,
  input  logic [15:0]               addr,
  input  logic [7:0]                din,
  output logic                      wait_n,
  output logic [7:0]                rdata
);

  localparam int idx_w = $clog2(mem_words);
  localparam logic [3:0] wait_reg = 4'd14;
  localparam logic [3:0] vec_reg  = 4'd15;

  logic [7:0]       mem [mem_words];
  logic [7:0]       io_regs [16];
  logic [7:0]       wait_cnt;  // Stall cycles still owed
  logic [idx_w-1:0] mem_idx;
  logic [3:0]       io_idx;
  logic             wr_hit;    // Write strobed by this access request

  assign mem_idx = addr[idx_w-1:0]; // Upper address bits alias
  assign io_idx  = addr[3:0];
  assign wr_hit  = access_req && strobes.wr;

  // Memory and I/O register writes
  always_ff @(posedge cpu_bus or negedge arst_n)
  begin
    if (!arst_n)
    begin
      for (int i = 0; i < mem_words; i++)
        mem[i] <= 8'd0;
      for (int j = 0; j < 16; j++)
        io_regs[j] <= 8'd0; // Clears W, so no wait states after reset
    end
    else if (wr_hit)
    begin
      if (strobes.mreq)
        mem[mem_idx] <= din;
      else if (strobes.iorq)
        io_regs[io_idx] <= din;
    end
  end

  // Wait counter, reloaded at the start of every access
  always_ff @(posedge cpu_bus or negedge arst_n)
  begin
    if (!arst_n)
      wait_cnt <= 8'd0;
    else if (access_req)
      wait_cnt <= io_regs[wait_reg];
    else if (wait_cnt != 8'd0)
      wait_cnt <= wait_cnt - 8'd1;
  end

  // Low for exactly W rising edges after the request
  assign wait_n = (wait_cnt == 8'd0);

  // Read data straight from the address and the current strobes
  always_comb
  begin
    if (strobes.iorq && strobes.m1)
      rdata = io_regs[vec_reg];  // Interrupt vector
    else if (strobes.iorq)
      rdata = io_regs[io_idx];
    else
      rdata = mem[mem_idx];
  end

endmodule

// ==== src/z80_bus_top.sv ====
// Z80 bus cycle engine top level
// Connects the cycle sequencer, the falling-edge strobe generator
// and the memory and I/O target model
`timescale 1ns/1ps

module z80_bus_top #(
  parameter bit t2_write  = 1'b1,
  parameter int mem_words = 256
) (
  input  logic                      cpu_bus,
  input  logic                      arst_n,
  input  logic                      cmd_valid,
  input  z80_bus_pkg::bus_req_t     cmd,
  output logic                      busy,
  output logic                      rsp_valid,
  output z80_bus_pkg::bus_rsp_t     rsp,
  output z80_bus_pkg::bus_strobes_t strobes,
  output logic                      access_req,
  output logic [15:0]               addr,
  output logic                      wait_n
);
  import z80_bus_pkg::*;

  cycle_info_t cycle;  // T-state and cycle kind to the decoder
  logic [7:0]  dout;   // Write data bus
  logic [7:0]  rdata;  // Read data from the target

  cycle_sequencer u_seq (
    .cpu_bus   (cpu_bus),
    .arst_n    (arst_n),
    .cmd_valid (cmd_valid),
    .cmd       (cmd),
    .wait_n    (wait_n),
    .rdata     (rdata),
    .busy      (busy),
    .cycle     (cycle),
    .addr      (addr),
    .dout      (dout),
    .rsp_valid (rsp_valid),
    .rsp       (rsp)
  );

  bus_strobe_gen #(.t2_write(t2_write)) u_strobe (
    .cpu_bus    (cpu_bus),
    .arst_n     (arst_n),
    .cycle      (cycle),
    .wait_n     (wait_n),
    .strobes    (strobes),
    .access_req (access_req)
  );

  bus_target #(.mem_words(mem_words)) u_target (
    .cpu_bus    (cpu_bus),
    .arst_n     (arst_n),
    .strobes    (strobes),
    .access_req (access_req),
    .addr       (addr),
    .din        (dout),
    .wait_n     (wait_n),
    .rdata      (rdata)
  );

endmodule

// ==== tests/z80_bus_props.sv ====
// Strobe protocol properties for the bus strobe generator
// Bound into every bus_strobe_gen instance and sampled on the rising
// edge, half a cycle after the strobes change
`timescale 1ns/1ps

module z80_bus_props (
  input logic                      cpu_bus,
  input logic                      arst_n,
  input z80_bus_pkg::bus_strobes_t strobes,
  input logic                      access_req
);

  // One request per access, the acknowledge flop must block a second
  single_req: assert property (@(posedge cpu_bus) disable iff (!arst_n)
    access_req |=> !access_req)
    else $error("access_req stayed high for two cycles");

  // Read and write direction are exclusive
  rd_wr_excl: assert property (@(posedge cpu_bus) disable iff (!arst_n)
    !(strobes.rd && strobes.wr))
    else $error("rd and wr active together");

  // Memory and I/O space never selected at once outside refresh
  sel_excl: assert property (@(posedge cpu_bus) disable iff (!arst_n)
    !(strobes.mreq && strobes.iorq && !strobes.rfsh))
    else $error("mreq and iorq active together");

  rfsh_mreq: assert property (@(posedge cpu_bus) disable iff (!arst_n)
    strobes.rfsh |-> strobes.mreq)
    else $error("rfsh active without mreq");

endmodule

bind bus_strobe_gen z80_bus_props props0 (
  .cpu_bus    (cpu_bus),
  .arst_n     (arst_n),
  .strobes    (strobes),
  .access_req (access_req)
);

// ==== tests/tb_z80_bus.sv ====
// Testbench for the Z80 bus cycle engine
// Drives single host commands, predicts read data and latency from a
// reference model of memory and I/O registers, and checks every response,
// the strobe pattern of each cycle and the refresh address
`timescale 1ns/1ps

module tb_z80_bus;
  import z80_bus_pkg::*;

  localparam int clk_period   = 100;
  localparam int reset_cycles = 4;
  localparam int num_cmds     = 70; // Upper bound on commands issued below
  localparam int max_w        = 3;
  localparam int watchdog_ns  = num_cmds * (8 + max_w) * clk_period + reset_cycles * clk_period;

  logic         cpu_bus;
  logic         arst_n;
  logic         cmd_valid;
  bus_req_t     cmd;
  logic         busy;
  logic         rsp_valid;
  bus_rsp_t     rsp;
  bus_strobes_t strobes;
  logic         access_req;
  logic [15:0]  addr;
  logic         wait_n;

  logic [7:0]  ref_mem [256]; // Expected memory contents
  logic [7:0]  ref_io [16];   // Expected I/O registers
  logic [6:0]  ref_fetch_cnt; // Fetches completed so far
  bus_cmd_e    exp_cmd_q [$];
  logic [7:0]  exp_rdata_q [$];
  int          exp_lat_q [$];
  int          exp_w_q [$];   // Wait states owed by each command
  int          issue_q [$];   // Cycle of the accepting edge
  int          cycle_cnt;
  int          rsp_cnt;
  int          acc_cnt;       // access_req pulses seen
  int          accepted_cnt;
  int          mismatch_cnt;
  int          fail_cnt;
  int          wait_low_cnt;  // Cycles with wait_n low in the current command
  logic        seen_m1;
  logic        seen_rfsh;
  logic        seen_iorq;
  logic        seen_mreq;
  logic        seen_rd;
  logic [31:0] rng;

  z80_bus_top #(.t2_write(1'b1), .mem_words(256)) dut0 (
    .cpu_bus    (cpu_bus),
    .arst_n     (arst_n),
    .cmd_valid  (cmd_valid),
    .cmd        (cmd),
    .busy       (busy),
    .rsp_valid  (rsp_valid),
    .rsp        (rsp),
    .strobes    (strobes),
    .access_req (access_req),
    .addr       (addr),
    .wait_n     (wait_n)
  );

  initial cpu_bus = 1'b0;
  always #(clk_period / 2) cpu_bus = ~cpu_bus;

  always @(posedge cpu_bus) cycle_cnt = cycle_cnt + 1; // Read only off the edge

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Read data the target must return for a command
  function automatic logic [7:0] ref_rdata(input bus_req_t r);
    case (r.cmd)
      cmd_fetch, cmd_mem_rd: return ref_mem[r.addr[7:0]];
      cmd_io_rd:             return ref_io[r.addr[3:0]];
      cmd_int_ack:           return ref_io[15]; // Vector register
      default:               return 8'h00;
    endcase
  endfunction

  // Cycles from the command edge to rsp_valid with one more for the refresh state
  function automatic int ref_latency(input bus_cmd_e c);
    int w;
    w = int'(ref_io[14]);
    return (c == cmd_fetch) ? 5 + w : 4 + w;
  endfunction

  task automatic next_rand(output logic [31:0] v);
    rng = xorshift32(rng);
    v   = rng;
  endtask

  task automatic apply_write(input bus_req_t r);
    if (r.cmd == cmd_mem_wr)
      ref_mem[r.addr[7:0]] = r.wdata;
    else if (r.cmd == cmd_io_wr)
      ref_io[r.addr[3:0]] = r.wdata;
  endtask

  // Issues one command and waits for its response, optionally holding
  // cmd_valid one more cycle with a write that the engine must drop
  task automatic issue(input bus_cmd_e c, input logic [15:0] a, input logic [7:0] d,
                       input bit strobe_again);
    bus_req_t r;
    int       start;
    int       guard;
    r.cmd   = c;
    r.addr  = a;
    r.wdata = d;
    @(posedge cpu_bus);
    #5;
    cmd_valid    = 1'b1;
    cmd          = r;
    seen_m1      = 1'b0;
    seen_rfsh    = 1'b0;
    seen_iorq    = 1'b0;
    seen_mreq    = 1'b0;
    seen_rd      = 1'b0;
    wait_low_cnt = 0;
    exp_cmd_q.push_back(c);
    exp_rdata_q.push_back(ref_rdata(r));
    exp_lat_q.push_back(ref_latency(c));
    exp_w_q.push_back(int'(ref_io[14])); // Loaded before this access can change it
    issue_q.push_back(cycle_cnt + 1);
    apply_write(r);
    accepted_cnt++;
    start = rsp_cnt;
    @(posedge cpu_bus);
    #5;
    assert (busy)
    else
    begin
      $display("MISMATCH busy got %h exp %h", busy, 1'b1);
      mismatch_cnt++;
    end
    if (strobe_again)
    begin
      cmd.cmd   = cmd_mem_wr; // Engine is busy now, so this write is lost
      cmd.wdata = ~d;
      @(posedge cpu_bus);
      #5;
    end
    cmd_valid = 1'b0;
    guard = 0;
    while (rsp_cnt == start && guard < 64)
    begin
      @(posedge cpu_bus);
      guard++;
    end
    assert (rsp_cnt != start)
    else
    begin
      $display("ERROR: no response to command %s at address %h", c.name(), a);
      fail_cnt++;
    end
  endtask

  task automatic check_response();
    bus_cmd_e   c;
    logic [7:0] exp_rd;
    int         exp_lat;
    int         exp_w;
    int         lat;
    if (exp_cmd_q.size() == 0)
    begin
      $display("ERROR: response arrived with no command outstanding");
      fail_cnt++;
      return;
    end
    c       = exp_cmd_q.pop_front();
    exp_rd  = exp_rdata_q.pop_front();
    exp_lat = exp_lat_q.pop_front();
    exp_w   = exp_w_q.pop_front();
    lat     = cycle_cnt - issue_q.pop_front();
    assert (lat == exp_lat)
    else
    begin
      $display("MISMATCH latency of %s got %h exp %h", c.name(), lat, exp_lat);
      mismatch_cnt++;
    end
    assert (wait_low_cnt == exp_w)
    else
    begin
      $display("MISMATCH wait_n low cycles of %s got %h exp %h", c.name(), wait_low_cnt,
               exp_w);
      mismatch_cnt++;
    end
    assert (!busy)
    else
    begin
      $display("MISMATCH busy got %h exp %h", busy, 1'b0);
      mismatch_cnt++;
    end
    if (c != cmd_mem_wr && c != cmd_io_wr)
    begin
      assert (rsp.rdata == exp_rd)
      else
      begin
        $display("MISMATCH rsp.rdata of %s got %h exp %h", c.name(), rsp.rdata, exp_rd);
        mismatch_cnt++;
      end
    end
    assert (rsp.int_ack_seen == (c == cmd_int_ack))
    else
    begin
      $display("MISMATCH rsp.int_ack_seen got %h exp %h", rsp.int_ack_seen, c == cmd_int_ack);
      mismatch_cnt++;
    end
    if (c == cmd_io_rd)
      assert (seen_iorq && !seen_mreq)
      else
      begin
        $display("ERROR: I/O read did not show iorq alone");
        fail_cnt++;
      end
    if (c == cmd_fetch)
    begin
      assert (seen_m1 && seen_rfsh)
      else
      begin
        $display("ERROR: fetch did not show m1 followed by refresh");
        fail_cnt++;
      end
      ref_fetch_cnt = ref_fetch_cnt + 7'd1;
    end
    if (c == cmd_int_ack)
      assert (!seen_rd && seen_iorq && seen_m1)
      else
      begin
        $display("ERROR: interrupt acknowledge strobes were wrong");
        fail_cnt++;
      end
  endtask

  // Strobes settle after the falling edge, addr after the rising one
  always @(negedge cpu_bus)
  begin
    #20;
    if (arst_n)
    begin
      if (access_req) acc_cnt++;
      if (!wait_n) wait_low_cnt++;
      if (strobes.m1) seen_m1 = 1'b1;
      if (strobes.iorq) seen_iorq = 1'b1;
      if (strobes.mreq && !strobes.rfsh) seen_mreq = 1'b1;
      if (strobes.rd) seen_rd = 1'b1;
      if (strobes.rfsh)
      begin
        seen_rfsh = 1'b1;
        assert (strobes.mreq && addr[6:0] == ref_fetch_cnt)
        else
        begin
          $display("MISMATCH refresh addr got %h exp %h", addr[6:0], ref_fetch_cnt);
          mismatch_cnt++;
        end
      end
      if (rsp_valid)
      begin
        rsp_cnt++;
        check_response();
      end
    end
  end

  initial
  begin
    #(watchdog_ns);
    $display("ERROR: watchdog expired before the tests finished");
    $display("sim failed");
    $finish;
  end

  initial
  begin : main_seq
    logic [31:0] v;
    logic [15:0] wr_addr [8];
    logic [7:0]  w_vals [3];
    arst_n        = 1'b0;
    cmd_valid     = 1'b0;
    cmd           = '0;
    rng           = 32'h4785;
    cycle_cnt     = 0;
    rsp_cnt       = 0;
    acc_cnt       = 0;
    accepted_cnt  = 0;
    mismatch_cnt  = 0;
    fail_cnt      = 0;
    wait_low_cnt  = 0;
    ref_fetch_cnt = 7'd0;
    seen_m1       = 1'b0;
    seen_rfsh     = 1'b0;
    seen_iorq     = 1'b0;
    seen_mreq     = 1'b0;
    seen_rd       = 1'b0;
    w_vals        = '{8'd0, 8'd1, 8'd3};
    for (int i = 0; i < 256; i++) ref_mem[i] = 8'h00;
    for (int i = 0; i < 16; i++) ref_io[i] = 8'h00;
    repeat (reset_cycles) @(posedge cpu_bus);
    #5;
    arst_n = 1'b1;

    // Memory writes then reads back, plus one likely fresh address
    for (int i = 0; i < 8; i++)
    begin
      next_rand(v);
      wr_addr[i] = v[15:0];
      issue(cmd_mem_wr, v[15:0], v[23:16], 1'b0);
    end
    for (int i = 0; i < 8; i++) issue(cmd_mem_rd, wr_addr[i], 8'h00, 1'b0);
    next_rand(v);
    issue(cmd_mem_rd, v[15:0], 8'h00, 1'b0);

    // I/O registers 0 to 13 with random upper address bits
    for (int r = 0; r < 14; r++)
    begin
      next_rand(v);
      issue(cmd_io_wr, {v[15:4], 4'(r)}, v[23:16], 1'b0);
    end
    for (int r = 0; r < 14; r++)
    begin
      next_rand(v);
      issue(cmd_io_rd, {v[15:4], 4'(r)}, 8'h00, 1'b0);
    end

    // Wait count in register 14 stretches every later access
    for (int k = 0; k < 3; k++)
    begin
      issue(cmd_io_wr, 16'h000e, w_vals[k], 1'b0);
      next_rand(v);
      issue(cmd_mem_wr, v[15:0], v[31:24], 1'b0);
      issue(cmd_mem_rd, v[15:0], 8'h00, 1'b0);
      issue(cmd_fetch, v[15:0], 8'h00, 1'b0);
    end

    // More fetches to walk the refresh counter
    for (int i = 0; i < 4; i++)
    begin
      next_rand(v);
      issue(cmd_fetch, v[15:0], 8'h00, 1'b0);
    end

    // Interrupt vector through register 15
    next_rand(v);
    issue(cmd_io_wr, 16'h000f, v[7:0], 1'b0);
    issue(cmd_int_ack, v[31:16], 8'h00, 1'b0);

    // Second strobe while busy must not write or respond
    next_rand(v);
    issue(cmd_mem_rd, v[15:0], 8'h00, 1'b1);
    issue(cmd_mem_rd, v[15:0], 8'h00, 1'b0);

    repeat (4) @(posedge cpu_bus);
    assert (acc_cnt == accepted_cnt)
    else
    begin
      $display("ERROR: %0d access requests for %0d commands", acc_cnt, accepted_cnt);
      fail_cnt++;
    end
    assert (rsp_cnt == accepted_cnt)
    else
    begin
      $display("ERROR: %0d responses for %0d commands", rsp_cnt, accepted_cnt);
      fail_cnt++;
    end
    $display("errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
    if (mismatch_cnt == 0 && fail_cnt == 0)
      $display("sim passed");
    else
      $display("sim failed");
    $finish;
  end

endmodule

// ==== filelist.f ====
src/z80_bus_pkg.sv
src/cycle_sequencer.sv
src/bus_strobe_gen.sv
src/bus_target.sv
src/z80_bus_top.sv
tests/z80_bus_props.sv
tests/tb_z80_bus.sv

// ==== run.sh ====
#!/bin/sh
# Builds the testbench with Verilator, runs it and looks for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f --top-module tb_z80_bus \
  -o sim_z80_bus \
  && ./obj_dir/sim_z80_bus | tee /dev/stderr | grep -qx "sim passed" \
  && echo "run ok" \
  || { echo "run failed"; exit 1; }
